// ==== hdl/wb_bus_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Wishbone bus package
// Bus widths and the slave address map shared by the
// interconnect and the register slaves
//////////////////////////////////////////////////////////////////////

package wb_bus_pkg;

   // Data and address widths
   localparam int adr_width = 4;
   localparam int dat_width = 8;

   // Address bit that picks the slave
   localparam int slave_sel_bit = 3;

   // Slave codes seen on the select bit
   localparam logic pic_slave   = 1'b0;
   localparam logic timer_slave = 1'b1;

endpackage

// ==== hdl/pic_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Interrupt controller package
// Level count, register offsets of the controller and timer,
// and the command word field layout
//////////////////////////////////////////////////////////////////////

package pic_pkg;

   localparam int num_levels  = 8;
   localparam int level_width = 3;

   // Controller register offsets
   localparam logic [2:0] reg_cmd    = 3'd0;
   localparam logic [2:0] reg_mask   = 3'd1;
   localparam logic [2:0] reg_vector = 3'd2;
   localparam logic [2:0] reg_base   = 3'd3;

   // Timer register offsets
   localparam logic [2:0] reg_tmr_reload = 3'd0;
   localparam logic [2:0] reg_tmr_ctrl   = 3'd1;
   localparam logic [2:0] reg_tmr_count  = 3'd2;

   // Command word layout, kind in bits 4:3
   localparam int         cmd_kind_lsb  = 3;
   localparam logic [1:0] cmd_kind_eoi  = 2'b00;
   localparam logic [1:0] cmd_kind_ocw3 = 2'b01;

   // OCW3 read select in bits 1:0
   localparam int         ocw3_rsel_lsb = 0;
   localparam logic [1:0] rsel_irr      = 2'b10;
   localparam logic [1:0] rsel_isr      = 2'b11;

endpackage

// ==== hdl/wb_if.sv ====
//////////////////////////////////////////////////////////////////////
// Wishbone classic interface
// One master/slave link with registered single-cycle ack
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface wb_if;

   logic                             cyc;
   logic                             stb;
   logic                             we;
   logic [wb_bus_pkg::adr_width-1:0] adr;
   logic [wb_bus_pkg::dat_width-1:0] dat_w;
   logic [wb_bus_pkg::dat_width-1:0] dat_r;
   logic                             ack;

   // Master side holds cyc, stb, adr and dat_w until ack
   modport master (
      output cyc, stb, we, adr, dat_w,
      input  dat_r, ack
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w,
      output dat_r, ack
   );

endinterface

// ==== hdl/wb_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// Wishbone arbiter and decoder
// Grants one of two masters, engine first on a tie, and routes
// the granted cycle to the controller or the timer by address
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module wb_arbiter (
   input  logic clk,
   input  logic rst,
   wb_if.slave  m_host,
   wb_if.slave  m_eng,
   wb_if.master s_pic,
   wb_if.master s_tmr
);

   typedef enum logic [1:0] {
      own_none,
      own_host,
      own_eng
   } owner_t;

   owner_t owner;

   // Granted master's request
   logic                             cyc;
   logic                             stb;
   logic                             we;
   logic [wb_bus_pkg::adr_width-1:0] adr;
   logic [wb_bus_pkg::dat_width-1:0] dat_w;

   // Selected slave's response
   logic                             to_tmr;
   logic [wb_bus_pkg::dat_width-1:0] dat_r;
   logic                             ack;

   // Grant is taken only from idle and kept while the owner holds cyc
   always_ff @(posedge clk) begin
      if (rst) begin
         owner <= own_none;
      end else begin
         case (owner)
            own_none: begin
               if (m_eng.cyc)
                  owner <= own_eng;
               else if (m_host.cyc)
                  owner <= own_host;
            end
            own_host: if (!m_host.cyc) owner <= own_none;
            own_eng:  if (!m_eng.cyc) owner <= own_none;
            default:  owner <= own_none;
         endcase
      end
   end

   always_comb begin
      case (owner)
         own_host: begin
            cyc   = m_host.cyc;
            stb   = m_host.stb;
            we    = m_host.we;
            adr   = m_host.adr;
            dat_w = m_host.dat_w;
         end
         own_eng: begin
            cyc   = m_eng.cyc;
            stb   = m_eng.stb;
            we    = m_eng.we;
            adr   = m_eng.adr;
            dat_w = m_eng.dat_w;
         end
         default: begin
            cyc   = 1'b0;
            stb   = 1'b0;
            we    = 1'b0;
            adr   = '0;
            dat_w = '0;
         end
      endcase
   end

   // Address decode
   assign to_tmr = (adr[wb_bus_pkg::slave_sel_bit] == wb_bus_pkg::timer_slave);

   assign s_pic.cyc   = cyc & (adr[wb_bus_pkg::slave_sel_bit] == wb_bus_pkg::pic_slave);
   assign s_pic.stb   = stb & (adr[wb_bus_pkg::slave_sel_bit] == wb_bus_pkg::pic_slave);
   assign s_pic.we    = we;
   assign s_pic.adr   = adr;
   assign s_pic.dat_w = dat_w;

   assign s_tmr.cyc   = cyc & to_tmr;
   assign s_tmr.stb   = stb & to_tmr;
   assign s_tmr.we    = we;
   assign s_tmr.adr   = adr;
   assign s_tmr.dat_w = dat_w;

   // Response goes back to the owner only
   assign dat_r = to_tmr ? s_tmr.dat_r : s_pic.dat_r;
   assign ack   = to_tmr ? s_tmr.ack : s_pic.ack;

   assign m_host.dat_r = dat_r;
   assign m_host.ack   = (owner == own_host) & ack;
   assign m_eng.dat_r  = dat_r;
   assign m_eng.ack    = (owner == own_eng) & ack;

endmodule

// ==== hdl/pic_core.sv ====
//////////////////////////////////////////////////////////////////////
// Programmable interrupt controller, 8259 style
// Edge-latched request, mask and in-service registers with fixed
// priority (level 0 highest), full nesting and a bus register file
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pic_core (
   input  logic                           clk,
   input  logic                           rst,
   wb_if.slave                            bus,
   input  logic [pic_pkg::num_levels-1:0] ir,
   output logic                           intr
);

   logic [pic_pkg::num_levels-1:0]  ir_q;
   logic [pic_pkg::num_levels-1:0]  irr;
   logic [pic_pkg::num_levels-1:0]  imr;
   logic [pic_pkg::num_levels-1:0]  isr;
   logic [pic_pkg::num_levels-1:0]  pending;
   logic [pic_pkg::num_levels-1:0]  pend_low;
   logic [pic_pkg::num_levels-1:0]  isr_low;
   logic [pic_pkg::level_width-1:0] pend_lvl;
   logic [pic_pkg::level_width-1:0] isr_lvl;
   logic [wb_bus_pkg::dat_width-1:pic_pkg::level_width] base;
   logic                            rd_isr;

   logic                                 acc;
   logic [wb_bus_pkg::slave_sel_bit-1:0] offset;
   logic [1:0]                           cmd_kind;
   logic [1:0]                           rsel;
   logic                                 vec_ack;
   logic                                 eoi;

   // Index of the lowest set bit, zero when none
   function automatic logic [pic_pkg::level_width-1:0] low_idx(
      input logic [pic_pkg::num_levels-1:0] v
   );
      logic [pic_pkg::level_width-1:0] idx;
      idx = '0;
      for (int i = pic_pkg::num_levels - 1; i >= 0; i--) begin
         if (v[i])
            idx = pic_pkg::level_width'(i);
      end
      return idx;
   endfunction

   // Priority resolution
   assign pending  = irr & ~imr;
   assign pend_low = pending & (~pending + 1'b1);
   assign isr_low  = isr & (~isr + 1'b1);
   assign pend_lvl = low_idx(pending);
   assign isr_lvl  = low_idx(isr);

   // Only a level above everything in service may interrupt
   assign intr = (|pending) & (~(|isr) | (pend_lvl < isr_lvl));

   // Bus decode
   assign acc      = bus.cyc & bus.stb & ~bus.ack;
   assign offset   = bus.adr[wb_bus_pkg::slave_sel_bit-1:0];
   assign cmd_kind = bus.dat_w[pic_pkg::cmd_kind_lsb +: 2];
   assign rsel     = bus.dat_w[pic_pkg::ocw3_rsel_lsb +: 2];
   assign vec_ack  = acc & ~bus.we & (offset == pic_pkg::reg_vector) & intr;
   assign eoi      = acc & bus.we & (offset == pic_pkg::reg_cmd)
                     & (cmd_kind == pic_pkg::cmd_kind_eoi);

   // Request latch, a new edge wins over the acknowledge clear
   always_ff @(posedge clk) begin
      if (rst) begin
         ir_q <= '0;
         irr  <= '0;
      end else begin
         ir_q <= ir;
         irr  <= (irr & ~(vec_ack ? pend_low : '0)) | (ir & ~ir_q);
      end
   end

   // In service, set by the vector read and cleared by non-specific EOI
   always_ff @(posedge clk) begin
      if (rst) begin
         isr <= '0;
      end else if (vec_ack) begin
         isr <= isr | pend_low;
      end else if (eoi) begin
         isr <= isr & ~isr_low;
      end
   end

   // Mask, base and status select
   always_ff @(posedge clk) begin
      if (rst) begin
         imr    <= '0;
         base   <= '0;
         rd_isr <= 1'b0;
      end else if (acc && bus.we) begin
         case (offset)
            pic_pkg::reg_cmd: begin
               if (cmd_kind == pic_pkg::cmd_kind_ocw3) begin
                  if (rsel == pic_pkg::rsel_irr)
                     rd_isr <= 1'b0;
                  else if (rsel == pic_pkg::rsel_isr)
                     rd_isr <= 1'b1;
               end
            end
            pic_pkg::reg_mask: imr <= bus.dat_w;
            pic_pkg::reg_base: base <= bus.dat_w[wb_bus_pkg::dat_width-1:pic_pkg::level_width];
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst)
         bus.ack <= 1'b0;
      else
         bus.ack <= acc;
   end

   // Read data is captured with the ack
   always_ff @(posedge clk) begin
      if (acc && !bus.we) begin
         case (offset)
            pic_pkg::reg_cmd:    bus.dat_r <= rd_isr ? isr : irr;
            pic_pkg::reg_mask:   bus.dat_r <= imr;
            pic_pkg::reg_vector: bus.dat_r <= {base, pend_lvl};
            pic_pkg::reg_base:   bus.dat_r <= {base, pic_pkg::level_width'(0)};
            default:             bus.dat_r <= '0;
         endcase
      end
   end

endmodule

// ==== hdl/interval_timer.sv ====
//////////////////////////////////////////////////////////////////////
// Interval timer
// Reloadable down-counter that pulses tick for one cycle at zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module interval_timer (
   input  logic clk,
   input  logic rst,
   wb_if.slave  bus,
   output logic tick
);

   logic [wb_bus_pkg::dat_width-1:0]     reload;
   logic [wb_bus_pkg::dat_width-1:0]     count;
   logic                                 en;
   logic                                 acc;
   logic [wb_bus_pkg::slave_sel_bit-1:0] offset;

   assign acc    = bus.cyc & bus.stb & ~bus.ack;
   assign offset = bus.adr[wb_bus_pkg::slave_sel_bit-1:0];

   always_ff @(posedge clk) begin
      if (acc && bus.we && offset == pic_pkg::reg_tmr_reload)
         reload <= bus.dat_w;
   end

   // Ctrl write also restarts the count from reload
   always_ff @(posedge clk) begin
      if (rst) begin
         en    <= 1'b0;
         count <= '0;
         tick  <= 1'b0;
      end else if (acc && bus.we && offset == pic_pkg::reg_tmr_ctrl) begin
         en    <= bus.dat_w[0];
         count <= reload;
         tick  <= 1'b0;
      end else if (en) begin
         tick  <= (count == '0);
         count <= (count == '0) ? reload : count - 1'b1;
      end else begin
         tick <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst)
         bus.ack <= 1'b0;
      else
         bus.ack <= acc;
   end

   always_ff @(posedge clk) begin
      if (acc && !bus.we) begin
         case (offset)
            pic_pkg::reg_tmr_reload: bus.dat_r <= reload;
            pic_pkg::reg_tmr_ctrl:   bus.dat_r <= {{(wb_bus_pkg::dat_width - 1){1'b0}}, en};
            pic_pkg::reg_tmr_count:  bus.dat_r <= count;
            default:                 bus.dat_r <= '0;
         endcase
      end
   end

endmodule

// ==== hdl/int_ack_engine.sv ====
//////////////////////////////////////////////////////////////////////
// Interrupt acknowledge engine
// Bus master that reads the controller vector register on intr and
// offers the vector downstream with a valid/ready handshake
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module int_ack_engine (
   input  logic                             clk,
   input  logic                             rst,
   wb_if.master                             bus,
   input  logic                             intr,
   output logic [wb_bus_pkg::dat_width-1:0] vec_data,
   output logic                             vec_valid,
   input  logic                             vec_ready
);

   typedef enum logic [1:0] {
      st_idle,
      st_read,
      st_present
   } state_t;

   state_t state;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:    if (intr) state <= st_read;
            st_read:    if (bus.ack) state <= st_present;
            st_present: if (vec_ready) state <= st_idle;
            default:    state <= st_idle;
         endcase
      end
   end

   // Vector held until the consumer takes it
   always_ff @(posedge clk) begin
      if (state == st_read && bus.ack)
         vec_data <= bus.dat_r;
   end

   // Strobe drops the cycle after ack as state leaves read
   assign bus.cyc   = (state == st_read);
   assign bus.stb   = (state == st_read);
   assign bus.we    = 1'b0;
   assign bus.adr   = {wb_bus_pkg::pic_slave, pic_pkg::reg_vector};
   assign bus.dat_w = '0;

   assign vec_valid = (state == st_present);

endmodule

// ==== hdl/pic_subsys_top.sv ====
//////////////////////////////////////////////////////////////////////
// Interrupt subsystem top level
// Host port and acknowledge engine share one Wishbone bus to the
// interrupt controller and the interval timer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pic_subsys_top (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             host_cyc,
   input  logic                             host_stb,
   input  logic                             host_we,
   input  logic [wb_bus_pkg::adr_width-1:0] host_adr,
   input  logic [wb_bus_pkg::dat_width-1:0] host_dat_w,
   output logic [wb_bus_pkg::dat_width-1:0] host_dat_r,
   output logic                             host_ack,
   input  logic [7:1]                       ir_ext,
   output logic                             int_out,
   output logic [wb_bus_pkg::dat_width-1:0] vec_data,
   output logic                             vec_valid,
   input  logic                             vec_ready
);

   wb_if host_bus ();
   wb_if eng_bus ();
   wb_if pic_bus ();
   wb_if tmr_bus ();

   logic tick;

   // Host port onto its bus link
   assign host_bus.cyc   = host_cyc;
   assign host_bus.stb   = host_stb;
   assign host_bus.we    = host_we;
   assign host_bus.adr   = host_adr;
   assign host_bus.dat_w = host_dat_w;
   assign host_dat_r     = host_bus.dat_r;
   assign host_ack       = host_bus.ack;

   wb_arbiter wb_arbiter_i (
      .clk    (clk),
      .rst    (rst),
      .m_host (host_bus.slave),
      .m_eng  (eng_bus.slave),
      .s_pic  (pic_bus.master),
      .s_tmr  (tmr_bus.master)
   );

   // Timer tick is request line 0
   pic_core pic_core_i (
      .clk  (clk),
      .rst  (rst),
      .bus  (pic_bus.slave),
      .ir   ({ir_ext, tick}),
      .intr (int_out)
   );

   interval_timer interval_timer_i (
      .clk  (clk),
      .rst  (rst),
      .bus  (tmr_bus.slave),
      .tick (tick)
   );

   int_ack_engine int_ack_engine_i (
      .clk       (clk),
      .rst       (rst),
      .bus       (eng_bus.master),
      .intr      (int_out),
      .vec_data  (vec_data),
      .vec_valid (vec_valid),
      .vec_ready (vec_ready)
   );

endmodule

// ==== verif/pic_subsys_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Interrupt subsystem testbench
// Replays host accesses, request line changes and vector checks
// from a command file against the subsystem top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pic_subsys_tb;

   localparam int timeout_cycles = 200;

   logic                             clk;
   logic                             rst;
   logic                             host_cyc;
   logic                             host_stb;
   logic                             host_we;
   logic [wb_bus_pkg::adr_width-1:0] host_adr;
   logic [wb_bus_pkg::dat_width-1:0] host_dat_w;
   logic [wb_bus_pkg::dat_width-1:0] host_dat_r;
   logic                             host_ack;
   logic [7:1]                       ir_ext;
   logic                             int_out;
   logic [wb_bus_pkg::dat_width-1:0] vec_data;
   logic                             vec_valid;
   logic                             vec_ready;

   logic [31:0] lfsr;

   pic_subsys_top pic_subsys_top_inst (
      .clk        (clk),
      .rst        (rst),
      .host_cyc   (host_cyc),
      .host_stb   (host_stb),
      .host_we    (host_we),
      .host_adr   (host_adr),
      .host_dat_w (host_dat_w),
      .host_dat_r (host_dat_r),
      .host_ack   (host_ack),
      .ir_ext     (ir_ext),
      .int_out    (int_out),
      .vec_data   (vec_data),
      .vec_valid  (vec_valid),
      .vec_ready  (vec_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         val  = (val << 1) | int'(lfsr[0]);
      end
   endtask

   task automatic stop_on_failure();
      $display("Something failed");
      $fatal(1);
   endtask

   // One Wishbone classic cycle on the host port, plus one idle cycle
   task automatic host_access(input string name, input logic we,
         input logic [7:0] adr, input logic [7:0] wdat, output logic [7:0] rdat);
      int   gap;
      int   cycles;
      logic got_ack;
      draw_bits(2, gap);
      repeat (gap) @(posedge clk);
      host_cyc   <= 1'b1;
      host_stb   <= 1'b1;
      host_we    <= we;
      host_adr   <= adr[wb_bus_pkg::adr_width-1:0];
      host_dat_w <= wdat;
      rdat       = '0;
      got_ack    = 1'b0;
      cycles     = 0;
      // Outputs are sampled mid-cycle, away from the clock edge
      while (!got_ack && cycles < timeout_cycles) begin
         @(negedge clk);
         cycles++;
         if (host_ack) begin
            got_ack = 1'b1;
            rdat    = host_dat_r;
         end
      end
      @(posedge clk);
      host_cyc <= 1'b0;
      host_stb <= 1'b0;
      host_we  <= 1'b0;
      assert (got_ack) else begin
         $display("Timeout: no host_ack within %0d cycles in test %0s", timeout_cycles, name);
         stop_on_failure();
      end
      @(posedge clk);
   endtask

   // Waits for a vector, checks it, then accepts it after a random stall
   task automatic take_vector(input string name, input logic [7:0] expected);
      int         cycles;
      int         stall;
      logic       seen;
      logic [7:0] got;
      seen   = 1'b0;
      got    = '0;
      cycles = 0;
      while (!seen && cycles < timeout_cycles) begin
         @(negedge clk);
         cycles++;
         if (vec_valid) begin
            seen = 1'b1;
            got  = vec_data;
         end
      end
      assert (seen) else begin
         $display("Timeout: no vec_valid within %0d cycles in test %0s", timeout_cycles, name);
         stop_on_failure();
      end
      assert (got == expected) else begin
         $display("Error: test %0s expected vector %02h actual %02h", name, expected, got);
         stop_on_failure();
      end
      draw_bits(2, stall);
      repeat (stall) begin
         @(posedge clk);
         @(negedge clk);
         assert (vec_valid && vec_data == got) else begin
            $display("Vector was not held until vec_ready in test %0s", name);
            stop_on_failure();
         end
      end
      @(posedge clk);
      vec_ready <= 1'b1;
      @(posedge clk);
      vec_ready <= 1'b0;
   endtask

   // Neither an interrupt nor a vector may appear in this window
   task automatic expect_quiet(input string name, input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         assert (!int_out) else begin
            $display("Error: test %0s expected int_out 0 actual %b", name, int_out);
            stop_on_failure();
         end
         assert (!vec_valid) else begin
            $display("Error: test %0s expected vec_valid 0 actual %b", name, vec_valid);
            stop_on_failure();
         end
         @(posedge clk);
      end
   endtask

   task automatic run_command(input string name, input string op,
         input logic [7:0] adr, input logic [7:0] value);
      logic [7:0] rdat;
      if (op == "wr") begin
         host_access(name, 1'b1, adr, value, rdat);
      end else if (op == "rd") begin
         host_access(name, 1'b0, adr, 8'h00, rdat);
         assert (rdat == value) else begin
            $display("Error: test %0s expected %02h actual %02h", name, value, rdat);
            stop_on_failure();
         end
      end else if (op == "rdle") begin
         host_access(name, 1'b0, adr, 8'h00, rdat);
         assert (rdat <= value) else begin
            $display("Error: test %0s expected at most %02h actual %02h", name, value, rdat);
            stop_on_failure();
         end
      end else if (op == "ir") begin
         // Line 0 belongs to the timer
         ir_ext <= value[7:1];
         @(posedge clk);
      end else if (op == "vec") begin
         take_vector(name, value);
      end else if (op == "quiet") begin
         expect_quiet(name, int'(value));
      end else begin
         $display("Unknown operation %0s in test %0s", op, name);
         stop_on_failure();
      end
   endtask

   initial begin
      int         fd;
      int         code;
      int         commands;
      string      name;
      string      op;
      string      rest;
      logic [7:0] adr;
      logic [7:0] value;

      rst        = 1'b1;
      host_cyc   = 1'b0;
      host_stb   = 1'b0;
      host_we    = 1'b0;
      host_adr   = '0;
      host_dat_w = '0;
      ir_ext     = '0;
      vec_ready  = 1'b0;
      lfsr       = 32'hd7e6814a;
      commands   = 0;

      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      fd = $fopen("verif/pic_input.txt", "r");
      assert (fd != 0) else begin
         $display("Cannot open the command file verif/pic_input.txt");
         stop_on_failure();
      end

      code = $fscanf(fd, " %s", name);
      while (code == 1) begin
         if (name[0] == "#") begin
            code = $fgets(rest, fd);
         end else begin
            code = $fscanf(fd, " %s %h %h", op, adr, value);
            assert (code == 3) else begin
               $display("Malformed command line in test %0s", name);
               stop_on_failure();
            end
            run_command(name, op, adr, value);
            commands++;
         end
         code = $fscanf(fd, " %s", name);
      end
      $fclose(fd);

      assert (commands > 0) else begin
         $display("The command file held no commands");
         stop_on_failure();
      end
      $display("Everything OK");
      $finish;
   end

endmodule

// ==== verif/pic_input.txt ====
# columns: test operation address value, numbers in hex
# ops: wr, rd (expect), rdle (expect at most), ir (levels), vec (expect), quiet (cycles)
regs wr 1 a5
regs rd 1 a5
regs wr 3 c8
regs rd 3 c8
regs rd 1 a5
regs rd 0 00
regs rd 9 00
regs wr 1 00
regs rd 1 00
deliver wr 3 40
deliver ir 0 04
deliver vec 0 42
deliver wr 0 0b
deliver rd 0 04
deliver wr 0 0a
deliver rd 0 00
deliver wr 0 00
deliver ir 0 00
deliver wr 0 0b
deliver rd 0 00
prio ir 0 28
prio vec 0 43
prio wr 0 00
prio vec 0 45
prio wr 0 00
prio ir 0 00
mask wr 1 40
mask ir 0 40
mask quiet 0 14
mask wr 0 0a
mask rd 0 40
mask wr 1 00
mask vec 0 46
mask wr 0 00
mask ir 0 00
nest ir 0 10
nest vec 0 44
nest ir 0 90
nest quiet 0 14
nest ir 0 92
nest vec 0 41
nest wr 0 00
nest quiet 0 0a
nest wr 0 00
nest vec 0 47
nest wr 0 00
nest ir 0 00
nest wr 0 0b
nest rd 0 00
timer wr 8 05
timer wr 9 01
timer rd 9 01
timer vec 0 40
timer rdle a 05
timer wr 9 00
timer wr 1 01
timer wr 0 00
timer quiet 0 0a
timer rd 0 00
shared ir 0 06
shared rd 1 01
shared vec 0 41
shared wr 0 00
shared rd 3 40
shared rd 9 00
shared vec 0 42
shared rd 8 05
shared wr 0 00
shared quiet 0 0a
shared ir 0 00
shared rd 0 00

// ==== all.f ====
hdl/wb_bus_pkg.sv
hdl/pic_pkg.sv
hdl/wb_if.sv
hdl/wb_arbiter.sv
hdl/pic_core.sv
hdl/interval_timer.sv
hdl/int_ack_engine.sv
hdl/pic_subsys_top.sv
verif/pic_subsys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the interrupt subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module pic_subsys_tb \
   -f all.f \
   -o pic_subsys_sim

./obj_dir/pic_subsys_sim 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
   echo "Simulation result: FAIL"
   exit 1
fi

echo "Simulation result: PASS"
